// ==== mini_mips_pkg.sv ====
package mini_mips_pkg;

    parameter int WORD_WIDTH     = 32;
    parameter int REG_ADDR_WIDTH = 5;
    parameter int NUM_REGS       = 1 << REG_ADDR_WIDTH;

    typedef logic [WORD_WIDTH-1:0]     word_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // primary opcode in inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } op_e;

    // r-type function field in inst[5:0]
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLT   = 4'd5,
        ALU_LUI   = 4'd6,   // passes op2 through
        ALU_LOAD  = 4'd7,
        ALU_STORE = 4'd8
    } alu_op_e;

    parameter word_t NOP_INST = '0;

endpackage

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import mini_mips_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  stall_i,
    input  word_t rom_data_i,
    output word_t rom_addr_o,
    output logic  rom_ce_o,
    output word_t id_pc_o,
    output word_t id_inst_o
);

    word_t pc_q;
    logic  ce_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ce_q <= 1'b0;
        end else begin
            ce_q <= 1'b1;   // fetch starts one cycle after release
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else if (!ce_q) begin
            pc_q <= RESET_PC;
        end else if (!stall_i) begin
            pc_q <= pc_q + WORD_WIDTH'(4);
        end
    end

    // IF/ID register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_pc_o   <= '0;
            id_inst_o <= NOP_INST;
        end else if (!ce_q) begin
            id_pc_o   <= '0;
            id_inst_o <= NOP_INST;
        end else if (!stall_i) begin
            id_pc_o   <= pc_q;
            id_inst_o <= rom_data_i;
        end
    end

    assign rom_addr_o = pc_q;
    assign rom_ce_o   = ce_q;

endmodule

// ==== id_stage.sv ====
`timescale 1ns/1ps

module id_stage import mini_mips_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  word_t     inst_i,
    input  word_t     rdata1_i,
    input  word_t     rdata2_i,
    input  logic      ex_load_i,
    input  reg_addr_t ex_waddr_i,
    output reg_addr_t raddr1_o,
    output reg_addr_t raddr2_o,
    output logic      re1_o,
    output logic      re2_o,
    output logic      stall_o,
    output alu_op_e   ex_aluop_o,
    output word_t     ex_op1_o,
    output word_t     ex_op2_o,
    output word_t     ex_store_data_o,
    output reg_addr_t ex_waddr_o,
    output logic      ex_wreg_o
);

    op_e       opcode;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     imm_zext;
    word_t     imm_sext;
    word_t     imm;
    alu_op_e   aluop;
    logic      rtype;
    logic      itype;
    logic      is_store;
    logic      wreg;
    reg_addr_t waddr;

    assign opcode   = op_e'(inst_i[31:26]);
    assign funct    = funct_e'(inst_i[5:0]);
    assign rs       = inst_i[25:21];
    assign rt       = inst_i[20:16];
    assign rd       = inst_i[15:11];
    assign imm_zext = {16'h0000, inst_i[15:0]};
    assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};

    always_comb begin
        aluop = ALU_ADD;
        imm   = '0;
        rtype = 1'b0;
        itype = 1'b1;
        case (opcode)
            OP_SPECIAL: begin
                itype = 1'b0;
                rtype = 1'b1;
                case (funct)
                    FN_ADDU: aluop = ALU_ADD;
                    FN_SUBU: aluop = ALU_SUB;
                    FN_AND:  aluop = ALU_AND;
                    FN_OR:   aluop = ALU_OR;
                    FN_XOR:  aluop = ALU_XOR;
                    FN_SLT:  aluop = ALU_SLT;
                    default: rtype = 1'b0;   // includes the all-zero nop
                endcase
            end
            OP_ADDIU: imm = imm_sext;
            OP_ANDI: begin
                aluop = ALU_AND;
                imm   = imm_zext;
            end
            OP_ORI: begin
                aluop = ALU_OR;
                imm   = imm_zext;
            end
            OP_XORI: begin
                aluop = ALU_XOR;
                imm   = imm_zext;
            end
            OP_LUI: begin
                aluop = ALU_LUI;
                imm   = {inst_i[15:0], 16'h0000};
            end
            OP_LW: begin
                aluop = ALU_LOAD;
                imm   = imm_sext;
            end
            OP_SW: begin
                aluop = ALU_STORE;
                imm   = imm_sext;
            end
            default: itype = 1'b0;
        endcase
    end

    assign is_store = itype && (opcode == OP_SW);
    assign re1_o    = rtype || (itype && (opcode != OP_LUI));
    assign re2_o    = rtype || is_store;
    assign raddr1_o = rs;
    assign raddr2_o = rt;
    assign wreg     = rtype || (itype && !is_store);
    assign waddr    = rtype ? rd : rt;

    // loaded value not ready until MEM
    assign stall_o = ex_load_i && ((re1_o && (raddr1_o == ex_waddr_i)) ||
                                   (re2_o && (raddr2_o == ex_waddr_i)));

    // ID/EX register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_aluop_o <= ALU_ADD;
            ex_waddr_o <= '0;
            ex_wreg_o  <= 1'b0;
        end else if (stall_o) begin
            ex_aluop_o <= ALU_ADD;   // bubble
            ex_waddr_o <= '0;
            ex_wreg_o  <= 1'b0;
        end else begin
            ex_aluop_o <= aluop;
            ex_waddr_o <= waddr;
            ex_wreg_o  <= wreg;
        end
    end

    always_ff @(posedge clk) begin
        ex_op1_o        <= rdata1_i;
        ex_op2_o        <= rtype ? rdata2_i : imm;
        ex_store_data_o <= rdata2_i;
    end

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile import mini_mips_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    input  logic      re1_i,
    input  logic      re2_i,
    input  reg_addr_t wb_waddr_i,
    input  logic      wb_we_i,
    input  word_t     wb_wdata_i,
    input  reg_addr_t ex_waddr_i,
    input  logic      ex_we_i,
    input  word_t     ex_wdata_i,
    input  reg_addr_t mem_waddr_i,
    input  logic      mem_we_i,
    input  word_t     mem_wdata_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs_q [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_we_i && (wb_waddr_i != '0)) begin
            regs_q[wb_waddr_i] <= wb_wdata_i;
        end
    end

    // youngest producer wins
    function automatic word_t read_port(input reg_addr_t addr, input logic re);
        word_t data;
        if (!re || (addr == '0)) begin
            data = '0;
        end else if (ex_we_i && (ex_waddr_i == addr)) begin
            data = ex_wdata_i;
        end else if (mem_we_i && (mem_waddr_i == addr)) begin
            data = mem_wdata_i;
        end else if (wb_we_i && (wb_waddr_i == addr)) begin
            data = wb_wdata_i;   // same-cycle write-back
        end else begin
            data = regs_q[addr];
        end
        return data;
    endfunction

    always_comb begin
        rdata1_o = read_port(raddr1_i, re1_i);
        rdata2_o = read_port(raddr2_i, re2_i);
    end

endmodule

// ==== ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage import mini_mips_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  alu_op_e   aluop_i,
    input  word_t     op1_i,
    input  word_t     op2_i,
    input  word_t     store_data_i,
    input  reg_addr_t waddr_i,
    input  logic      wreg_i,
    output word_t     fwd_wdata_o,
    output reg_addr_t fwd_waddr_o,
    output logic      fwd_we_o,
    output logic      load_o,
    output alu_op_e   mem_aluop_o,
    output word_t     mem_result_o,
    output word_t     mem_store_data_o,
    output reg_addr_t mem_waddr_o,
    output logic      mem_wreg_o
);

    word_t result;

    always_comb begin
        case (aluop_i)
            ALU_SUB:   result = op1_i - op2_i;
            ALU_AND:   result = op1_i & op2_i;
            ALU_OR:    result = op1_i | op2_i;
            ALU_XOR:   result = op1_i ^ op2_i;
            ALU_SLT:   result = {{(WORD_WIDTH-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
            ALU_LUI:   result = op2_i;
            default:   result = op1_i + op2_i;   // add and load/store address
        endcase
    end

    assign load_o = (aluop_i == ALU_LOAD);

    // load data not known until MEM
    assign fwd_wdata_o = result;
    assign fwd_waddr_o = waddr_i;
    assign fwd_we_o    = wreg_i && !load_o;

    // EX/MEM register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_aluop_o <= ALU_ADD;
            mem_waddr_o <= '0;
            mem_wreg_o  <= 1'b0;
        end else begin
            mem_aluop_o <= aluop_i;
            mem_waddr_o <= waddr_i;
            mem_wreg_o  <= wreg_i;
        end
    end

    always_ff @(posedge clk) begin
        mem_result_o     <= result;
        mem_store_data_o <= store_data_i;
    end

endmodule

// ==== mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage import mini_mips_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  alu_op_e   aluop_i,
    input  word_t     result_i,
    input  word_t     store_data_i,
    input  reg_addr_t waddr_i,
    input  logic      wreg_i,
    input  word_t     ram_data_i,
    output word_t     ram_addr_o,
    output word_t     ram_wdata_o,
    output logic      ram_we_o,
    output logic      ram_ce_o,
    output word_t     fwd_wdata_o,
    output reg_addr_t fwd_waddr_o,
    output logic      fwd_we_o,
    output reg_addr_t wb_waddr_o,
    output logic      wb_we_o,
    output word_t     wb_wdata_o
);

    logic is_load;
    logic is_store;

    assign is_load  = (aluop_i == ALU_LOAD);
    assign is_store = (aluop_i == ALU_STORE);

    assign ram_ce_o    = is_load || is_store;
    assign ram_we_o    = is_store;
    assign ram_addr_o  = result_i;   // byte address from EX
    assign ram_wdata_o = store_data_i;

    assign fwd_wdata_o = is_load ? ram_data_i : result_i;
    assign fwd_waddr_o = waddr_i;
    assign fwd_we_o    = wreg_i;

    // MEM/WB register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_waddr_o <= '0;
            wb_we_o    <= 1'b0;
        end else begin
            wb_waddr_o <= waddr_i;
            wb_we_o    <= wreg_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_wdata_o <= fwd_wdata_o;
    end

endmodule

// ==== mini_mips.sv ====
`timescale 1ns/1ps

module mini_mips import mini_mips_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  arst_n_i,
    input  word_t rom_data_i,
    input  word_t ram_data_i,
    output word_t rom_addr_o,
    output logic  rom_ce_o,
    output word_t ram_addr_o,
    output word_t ram_wdata_o,
    output logic  ram_we_o,
    output logic  ram_ce_o
);

    // IF -> ID
    word_t     id_inst;
    logic      stall;

    // ID <-> regfile
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    logic      rf_re1;
    logic      rf_re2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;

    // ID/EX
    alu_op_e   ex_aluop;
    word_t     ex_op1;
    word_t     ex_op2;
    word_t     ex_store_data;
    reg_addr_t ex_waddr;
    logic      ex_wreg;

    // EX feedback
    word_t     ex_fwd_wdata;
    reg_addr_t ex_fwd_waddr;
    logic      ex_fwd_we;
    logic      ex_load;

    // EX/MEM
    alu_op_e   mem_aluop;
    word_t     mem_result;
    word_t     mem_store_data;
    reg_addr_t mem_waddr;
    logic      mem_wreg;

    // MEM feedback and MEM/WB
    word_t     mem_fwd_wdata;
    reg_addr_t mem_fwd_waddr;
    logic      mem_fwd_we;
    reg_addr_t wb_waddr;
    logic      wb_we;
    word_t     wb_wdata;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_stage_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .stall_i    (stall),
        .rom_data_i (rom_data_i),
        .rom_addr_o (rom_addr_o),
        .rom_ce_o   (rom_ce_o),
        .id_pc_o    (),             // pc not needed without branches
        .id_inst_o  (id_inst)
    );

    id_stage id_stage_i (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .inst_i          (id_inst),
        .rdata1_i        (rf_rdata1),
        .rdata2_i        (rf_rdata2),
        .ex_load_i       (ex_load),
        .ex_waddr_i      (ex_fwd_waddr),
        .raddr1_o        (rf_raddr1),
        .raddr2_o        (rf_raddr2),
        .re1_o           (rf_re1),
        .re2_o           (rf_re2),
        .stall_o         (stall),
        .ex_aluop_o      (ex_aluop),
        .ex_op1_o        (ex_op1),
        .ex_op2_o        (ex_op2),
        .ex_store_data_o (ex_store_data),
        .ex_waddr_o      (ex_waddr),
        .ex_wreg_o       (ex_wreg)
    );

    regfile regfile_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .raddr1_i    (rf_raddr1),
        .raddr2_i    (rf_raddr2),
        .re1_i       (rf_re1),
        .re2_i       (rf_re2),
        .wb_waddr_i  (wb_waddr),
        .wb_we_i     (wb_we),
        .wb_wdata_i  (wb_wdata),
        .ex_waddr_i  (ex_fwd_waddr),
        .ex_we_i     (ex_fwd_we),
        .ex_wdata_i  (ex_fwd_wdata),
        .mem_waddr_i (mem_fwd_waddr),
        .mem_we_i    (mem_fwd_we),
        .mem_wdata_i (mem_fwd_wdata),
        .rdata1_o    (rf_rdata1),
        .rdata2_o    (rf_rdata2)
    );

    ex_stage ex_stage_i (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .aluop_i          (ex_aluop),
        .op1_i            (ex_op1),
        .op2_i            (ex_op2),
        .store_data_i     (ex_store_data),
        .waddr_i          (ex_waddr),
        .wreg_i           (ex_wreg),
        .fwd_wdata_o      (ex_fwd_wdata),
        .fwd_waddr_o      (ex_fwd_waddr),
        .fwd_we_o         (ex_fwd_we),
        .load_o           (ex_load),
        .mem_aluop_o      (mem_aluop),
        .mem_result_o     (mem_result),
        .mem_store_data_o (mem_store_data),
        .mem_waddr_o      (mem_waddr),
        .mem_wreg_o       (mem_wreg)
    );

    mem_stage mem_stage_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .aluop_i      (mem_aluop),
        .result_i     (mem_result),
        .store_data_i (mem_store_data),
        .waddr_i      (mem_waddr),
        .wreg_i       (mem_wreg),
        .ram_data_i   (ram_data_i),
        .ram_addr_o   (ram_addr_o),
        .ram_wdata_o  (ram_wdata_o),
        .ram_we_o     (ram_we_o),
        .ram_ce_o     (ram_ce_o),
        .fwd_wdata_o  (mem_fwd_wdata),
        .fwd_waddr_o  (mem_fwd_waddr),
        .fwd_we_o     (mem_fwd_we),
        .wb_waddr_o   (wb_waddr),
        .wb_we_o      (wb_we),
        .wb_wdata_o   (wb_wdata)
    );

endmodule

// ==== mini_mips_asserts.sv ====
`timescale 1ns/1ps

module mini_mips_asserts import mini_mips_pkg::*; (
    input logic  clk,
    input logic  arst_n_i,
    input word_t rom_addr_i,
    input logic  rom_ce_i,
    input word_t ram_addr_i,
    input logic  ram_we_i,
    input logic  ram_ce_i
);

    int assert_errs = 0;

    we_needs_ce: assert property (@(posedge clk) disable iff (!arst_n_i)
        ram_we_i |-> ram_ce_i)
        else begin
            assert_errs++;
            $error("ram_we_o high without ram_ce_o");
        end

    rom_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        rom_ce_i |-> (rom_addr_i[1:0] == 2'b00))
        else begin
            assert_errs++;
            $error("rom_addr_o not word aligned");
        end

    ram_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        ram_ce_i |-> (ram_addr_i[1:0] == 2'b00))
        else begin
            assert_errs++;
            $error("ram_addr_o not word aligned");
        end

    strobes_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        !$isunknown({rom_ce_i, ram_ce_i, ram_we_i}))
        else begin
            assert_errs++;
            $error("unknown value on a memory strobe");
        end

endmodule

bind mini_mips mini_mips_asserts mini_mips_asserts_i (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .rom_addr_i (rom_addr_o),
    .rom_ce_i   (rom_ce_o),
    .ram_addr_i (ram_addr_o),
    .ram_we_i   (ram_we_o),
    .ram_ce_i   (ram_ce_o)
);

// ==== tb_mini_mips.sv ====
`timescale 1ns/1ps

module tb_mini_mips import mini_mips_pkg::*; ();

    localparam word_t RESET_PC  = 32'h0000_0400;
    localparam int    BODY_LEN  = 64;
    localparam int    ROM_WORDS = 128;
    localparam int    RAM_WORDS = 64;

    logic  clk;
    logic  arst_n_i;
    word_t rom_data_i;
    word_t ram_data_i;
    word_t rom_addr_o;
    logic  rom_ce_o;
    word_t ram_addr_o;
    word_t ram_wdata_o;
    logic  ram_we_o;
    logic  ram_ce_o;

    word_t       prog [ROM_WORDS] = '{default: '0};
    int          tag_of [ROM_WORDS] = '{default: 3};
    word_t       ram [RAM_WORDS];
    word_t       rom_word_idx;
    logic [15:0] lfsr_q = 16'd51;

    word_t exp_addr_q [$];
    word_t exp_data_q [$];
    int    exp_tag_q [$];
    int    exp_count;
    int    exp_stalls;
    int    stores_seen;
    int    fetch_holds;
    logic  fetch_seen;
    word_t last_fetch;
    int    errs [1:6] = '{default: 0};
    string test_name [1:6] = '{"reset and first fetch", "fetch order", "alu and forwarding",
                               "load-use stall", "register zero", "completion"};

    funct_e fn_tab [6]  = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT};
    op_e    iop_tab [5] = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};

    mini_mips #(
        .RESET_PC (RESET_PC)
    ) mini_mips_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .rom_data_i  (rom_data_i),
        .ram_data_i  (ram_data_i),
        .rom_addr_o  (rom_addr_o),
        .rom_ce_o    (rom_ce_o),
        .ram_addr_o  (ram_addr_o),
        .ram_wdata_o (ram_wdata_o),
        .ram_we_o    (ram_we_o),
        .ram_ce_o    (ram_ce_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fibonacci lfsr with taps 16 14 13 11
    function automatic int unsigned next_bits(input int n);
        int unsigned v;
        logic        fb;
        v = 0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = (v << 1) | fb;
        end
        return v;
    endfunction

    function automatic word_t fill_word(input int idx);
        return (32'h9e37_79b9 * word_t'(idx + 1)) ^ 32'h0000_a5a5;
    endfunction

    function automatic word_t enc_r(input funct_e fn, input reg_addr_t rs, input reg_addr_t rt,
                                    input reg_addr_t rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t enc_i(input op_e op, input reg_addr_t rs, input reg_addr_t rt,
                                    input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] word_offset();
        return 16'(4 * next_bits(6));
    endfunction

    function automatic word_t random_inst();
        int unsigned kind;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [15:0] imm;
        funct_e      fn;
        op_e         iop;
        kind = next_bits(3);
        rs   = reg_addr_t'(next_bits(3));   // 0 now and then
        rt   = reg_addr_t'(next_bits(3));
        rd   = reg_addr_t'(next_bits(3));
        imm  = 16'(next_bits(16));
        fn   = fn_tab[next_bits(3) % 6];
        iop  = iop_tab[next_bits(3) % 5];
        case (kind)
            0, 1, 2: return enc_r(fn, rs, rt, rd);
            3, 4, 5: return enc_i(iop, rs, rt, imm);
            6:       return enc_i(OP_LW, '0, rt, word_offset());
            default: return enc_i(OP_SW, '0, rt, word_offset());
        endcase
    endfunction

    task automatic build_program();
        int        i;
        reg_addr_t ld_reg;
        reg_addr_t src;
        reg_addr_t dst;
        i = 0;
        while (i < BODY_LEN) begin
            if ((i % 10 == 4) && (i + 3 <= BODY_LEN)) begin
                ld_reg      = reg_addr_t'(1 + next_bits(3) % 7);
                src         = reg_addr_t'(next_bits(3));
                dst         = reg_addr_t'(next_bits(3));
                prog[i]     = enc_i(OP_LW, '0, ld_reg, word_offset());
                prog[i + 1] = enc_r(fn_tab[next_bits(3) % 6], ld_reg, src, dst);   // uses load
                prog[i + 2] = enc_i(OP_SW, '0, dst, word_offset());
                tag_of[i + 2] = 4;
                i += 3;
            end else begin
                prog[i] = random_inst();
                i++;
            end
        end
        prog[BODY_LEN - 1] = enc_i(OP_ORI, '0, '0, 16'h5a5a);   // nonzero write to r0
        // dump r0..r7 to the top of ram
        for (int k = 0; k < 8; k++) begin
            prog[BODY_LEN + k]   = enc_i(OP_SW, '0, reg_addr_t'(k), 16'(4 * (56 + k)));
            tag_of[BODY_LEN + k] = (k == 0) ? 5 : 3;
        end
    endtask

    // in-order instruction model
    task automatic run_model();
        word_t       regs [32];
        word_t       dmem [RAM_WORDS];
        word_t       w;
        word_t       a;
        word_t       b;
        word_t       res;
        word_t       addr;
        word_t       sext;
        word_t       zext;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [15:0] imm;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   dst;
        logic        rd_rs;
        logic        rd_rt;
        logic        wr;
        logic        prev_load;
        reg_addr_t   prev_rt;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int j = 0; j < RAM_WORDS; j++) begin
            dmem[j] = fill_word(j);
        end
        prev_load = 1'b0;
        prev_rt   = '0;
        for (int i = 0; i < ROM_WORDS; i++) begin
            w     = prog[i];
            op    = w[31:26];
            fn    = w[5:0];
            rs    = w[25:21];
            rt    = w[20:16];
            imm   = w[15:0];
            a     = regs[rs];
            b     = regs[rt];
            sext  = {{16{imm[15]}}, imm};
            zext  = {16'h0000, imm};
            addr  = a + sext;
            rd_rs = 1'b1;
            rd_rt = 1'b0;
            wr    = 1'b1;
            dst   = rt;
            res   = '0;
            case (op)
                OP_SPECIAL: begin
                    rd_rt = 1'b1;
                    dst   = w[15:11];
                    case (fn)
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: begin   // nop
                            rd_rs = 1'b0;
                            rd_rt = 1'b0;
                            wr    = 1'b0;
                        end
                    endcase
                end
                OP_ADDIU: res = a + sext;
                OP_ANDI:  res = a & zext;
                OP_ORI:   res = a | zext;
                OP_XORI:  res = a ^ zext;
                OP_LUI: begin
                    rd_rs = 1'b0;
                    res   = {imm, 16'h0000};
                end
                OP_LW: res = dmem[addr[7:2]];
                OP_SW: begin
                    rd_rt = 1'b1;
                    wr    = 1'b0;
                    dmem[addr[7:2]] = b;
                    exp_addr_q.push_back(addr);
                    exp_data_q.push_back(b);
                    exp_tag_q.push_back(tag_of[i]);
                end
                default: begin
                    rd_rs = 1'b0;
                    wr    = 1'b0;
                end
            endcase
            if (prev_load && ((rd_rs && rs == prev_rt) || (rd_rt && rt == prev_rt))) begin
                exp_stalls++;
            end
            prev_load = (op == OP_LW);
            prev_rt   = rt;
            if (wr && dst != '0) begin
                regs[dst] = res;
            end
        end
        exp_count = exp_addr_q.size();
    endtask

    task automatic report_mismatch(input int test, input string what, input word_t exp_val,
                                   input word_t act_val);
        $display("[FAIL] %s (%s): expected %h, actual %h", test_name[test], what, exp_val,
                 act_val);
        errs[test]++;
    endtask

    task automatic check_store();
        word_t exp_addr;
        word_t exp_data;
        int    tag;
        if (exp_addr_q.size() == 0) begin
            $display("store to %h with data %h was not expected by the model", ram_addr_o,
                     ram_wdata_o);
            errs[6]++;
        end else begin
            exp_addr = exp_addr_q.pop_front();
            exp_data = exp_data_q.pop_front();
            tag      = exp_tag_q.pop_front();
            if (ram_addr_o !== exp_addr) begin
                report_mismatch(tag, "store address", exp_addr, ram_addr_o);
            end
            if (ram_wdata_o !== exp_data) begin
                report_mismatch(tag, "store data", exp_data, ram_wdata_o);
            end
        end
        stores_seen++;
    endtask

    task automatic print_result(input int test);
        $display("test %0d %s: %s", test, test_name[test], (errs[test] == 0) ? "passed" : "failed");
    endtask

    // rom and ram models
    always_comb begin
        rom_word_idx = (rom_addr_o - RESET_PC) >> 2;
        if (!rom_ce_o || rom_word_idx >= ROM_WORDS) begin
            rom_data_i = NOP_INST;
        end else begin
            rom_data_i = prog[rom_word_idx];
        end
    end

    assign ram_data_i = ram_ce_o ? ram[ram_addr_o[7:2]] : '0;

    always @(posedge clk) begin
        if (arst_n_i && ram_ce_o && ram_we_o) begin
            ram[ram_addr_o[7:2]] <= ram_wdata_o;
        end
    end

    // monitors sample mid-cycle
    always @(negedge clk) begin
        if (arst_n_i && ram_ce_o && ram_we_o) begin
            check_store();
        end
        if (arst_n_i && rom_ce_o) begin
            if (fetch_seen && rom_addr_o == last_fetch) begin
                fetch_holds++;   // stall hold
            end else if (fetch_seen && rom_addr_o !== last_fetch + 32'd4) begin
                report_mismatch(2, "next fetch address", last_fetch + 32'd4, rom_addr_o);
            end
            fetch_seen = 1'b1;
            last_fetch = rom_addr_o;
        end
    end

    initial begin
        int wait_cycles;
        int passed;
        int total;
        arst_n_i    = 1'b0;
        fetch_seen  = 1'b0;
        last_fetch  = '0;
        stores_seen = 0;
        fetch_holds = 0;
        exp_stalls  = 0;
        for (int j = 0; j < RAM_WORDS; j++) begin
            ram[j] = fill_word(j);
        end
        build_program();
        run_model();

        repeat (8) begin
            @(negedge clk);
            if (rom_ce_o !== 1'b0 || ram_ce_o !== 1'b0 || ram_we_o !== 1'b0) begin
                $display("a memory strobe was not low during reset");
                errs[1]++;
            end
        end
        arst_n_i = 1'b1;
        wait_cycles = 0;
        while (rom_ce_o !== 1'b1 && wait_cycles < 10) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (rom_ce_o !== 1'b1) begin
            $display("rom_ce_o did not rise within 10 cycles after reset release");
            errs[1]++;
        end else if (rom_addr_o !== RESET_PC) begin
            report_mismatch(1, "first fetch address", RESET_PC, rom_addr_o);
        end
        print_result(1);

        wait_cycles = 0;
        while (stores_seen < exp_count && wait_cycles < 400) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (stores_seen < exp_count) begin
            $display("timeout: %0d of %0d stores seen after 400 cycles", stores_seen, exp_count);
            errs[6]++;
        end else begin
            repeat (8) @(negedge clk);   // window for stray stores
        end
        if (fetch_holds != exp_stalls) begin
            report_mismatch(2, "stall holds", word_t'(exp_stalls), word_t'(fetch_holds));
        end
        if (stores_seen != exp_count) begin
            report_mismatch(6, "store count", word_t'(exp_count), word_t'(stores_seen));
        end
        for (int t = 2; t <= 6; t++) begin
            print_result(t);
        end

        passed = 0;
        total  = 0;
        for (int t = 1; t <= 6; t++) begin
            total += errs[t];
            if (errs[t] == 0) begin
                passed++;
            end
        end
        if (mini_mips_i.mini_mips_asserts_i.assert_errs != 0) begin
            $display("%0d concurrent assertion failures were reported",
                     mini_mips_i.mini_mips_asserts_i.assert_errs);
        end
        total += mini_mips_i.mini_mips_asserts_i.assert_errs;
        $display("%0d of 6 tests passed, %0d errors, %0d stores checked", passed, total,
                 stores_seen);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== mini_mips.f ====
mini_mips_pkg.sv
fetch_stage.sv
id_stage.sv
regfile.sv
ex_stage.sv
mem_stage.sv
mini_mips.sv
mini_mips_asserts.sv
tb_mini_mips.sv
